// File: hw/rv32_pkg.sv
`default_nettype none

package rv32_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;

  // major opcodes handled by the core
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111
  } opcode_e;

  // funct3 codes shared by the register and immediate forms
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct7, bit 30 picks sub and sra
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  typedef enum logic [3:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLT,
    SLL,
    SRL,
    SRA,
    PASS_B
  } alu_op_e;

  // one instruction word, seen as R, I or U format
  typedef union packed {
    struct packed {
      logic [6:0]            funct7;
      logic [REG_ADDR_W-1:0] rs2;
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [REG_ADDR_W-1:0] rd;
      logic [6:0]            opcode;
    } r;
    struct packed {
      logic [11:0]           imm;
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [REG_ADDR_W-1:0] rd;
      logic [6:0]            opcode;
    } i;
    struct packed {
      logic [19:0]           imm;
      logic [REG_ADDR_W-1:0] rd;
      logic [6:0]            opcode;
    } u;
  } instr_u;

endpackage

`default_nettype wire

// File: hw/fetch_stage.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_stage #(
  parameter logic [rv32_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  wire                       clk,
  input  wire                       arst_n,
  output logic                      ibus_cyc,
  output logic                      ibus_stb,
  output logic [rv32_pkg::XLEN-1:0] ibus_adr,
  input  wire                       ibus_ack,
  input  wire  [rv32_pkg::XLEN-1:0] ibus_rdata,
  output logic                      fetch_valid,
  output logic [rv32_pkg::XLEN-1:0] fetch_instr
);

  localparam logic [rv32_pkg::XLEN-1:0] PC_STEP = 4;

  logic                      bus_active;
  logic                      accept;
  logic [rv32_pkg::XLEN-1:0] pc;

  // word transferred at this edge
  assign accept = bus_active && ibus_ack;

  // cycle held open from the first clock after reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bus_active <= 1'b0;
    end else begin
      bus_active <= 1'b1;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= RESET_PC;
    end else if (accept) begin
      pc <= pc + PC_STEP;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      fetch_valid <= 1'b0;
    end else begin
      fetch_valid <= accept;
    end
  end

  // instruction word, only meaningful with fetch_valid
  always_ff @(posedge clk) begin
    if (accept) begin
      fetch_instr <= ibus_rdata;
    end
  end

  assign ibus_cyc = bus_active;
  assign ibus_stb = bus_active;
  assign ibus_adr = pc;

endmodule

`default_nettype wire

// File: hw/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
  input  wire                             clk,
  input  wire                             arst_n,
  input  wire                             fetch_valid,
  input  wire  [rv32_pkg::XLEN-1:0]       fetch_instr,
  output logic                            dec_valid,
  output rv32_pkg::alu_op_e               dec_alu_op,
  output logic [rv32_pkg::REG_ADDR_W-1:0] dec_rs1,
  output logic [rv32_pkg::REG_ADDR_W-1:0] dec_rs2,
  output logic [rv32_pkg::REG_ADDR_W-1:0] dec_rd,
  output logic [rv32_pkg::XLEN-1:0]       dec_imm,
  output logic                            dec_use_imm,
  output logic                            dec_write
);

  rv32_pkg::instr_u          instr;
  rv32_pkg::alu_op_e         alu_op;
  logic [rv32_pkg::XLEN-1:0] imm;
  logic                      is_op;
  logic                      is_op_imm;
  logic                      is_lui;
  logic                      is_shift;
  logic                      f3_ok;
  logic                      f7_ok;
  logic                      kept;

  assign instr = fetch_instr;

  assign is_op     = instr.r.opcode == rv32_pkg::OP;
  assign is_op_imm = instr.r.opcode == rv32_pkg::OP_IMM;
  assign is_lui    = instr.r.opcode == rv32_pkg::LUI;

  assign is_shift = (instr.r.funct3 == rv32_pkg::F3_SLL) ||
                    (instr.r.funct3 == rv32_pkg::F3_SRL_SRA);

  // alternate funct7 only for sub and sra
  assign f7_ok = (instr.r.funct7 == rv32_pkg::F7_BASE) ||
                 ((instr.r.funct7 == rv32_pkg::F7_ALT) &&
                  ((instr.r.funct3 == rv32_pkg::F3_SRL_SRA) ||
                   (is_op && instr.r.funct3 == rv32_pkg::F3_ADD_SUB)));

  // i-type only checks funct7 on shifts
  assign kept = is_lui ||
                (is_op && f3_ok && f7_ok) ||
                (is_op_imm && f3_ok && (!is_shift || f7_ok));

  always_comb begin
    f3_ok  = 1'b1;
    alu_op = rv32_pkg::ADD;
    case (instr.r.funct3)
      rv32_pkg::F3_ADD_SUB: alu_op = (is_op && instr.r.funct7[5]) ? rv32_pkg::SUB
                                                                   : rv32_pkg::ADD;
      rv32_pkg::F3_SLL:     alu_op = rv32_pkg::SLL;
      rv32_pkg::F3_SLT:     alu_op = rv32_pkg::SLT;
      rv32_pkg::F3_XOR:     alu_op = rv32_pkg::XOR;
      rv32_pkg::F3_SRL_SRA: alu_op = instr.r.funct7[5] ? rv32_pkg::SRA : rv32_pkg::SRL;
      rv32_pkg::F3_OR:      alu_op = rv32_pkg::OR;
      rv32_pkg::F3_AND:     alu_op = rv32_pkg::AND;
      default:              f3_ok  = 1'b0;
    endcase
    if (is_lui) begin
      alu_op = rv32_pkg::PASS_B;
    end
  end

  // lui immediate fills the upper 20 bits
  assign imm = is_lui ? {instr.u.imm, 12'b0}
                      : {{(rv32_pkg::XLEN - 12){instr.i.imm[11]}}, instr.i.imm};

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= fetch_valid && kept;
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_valid) begin
      dec_alu_op  <= alu_op;
      dec_rs1     <= instr.r.rs1;
      dec_rs2     <= instr.r.rs2;
      dec_rd      <= instr.r.rd;
      dec_imm     <= imm;
      dec_use_imm <= !is_op;
      dec_write   <= instr.r.rd != '0;
    end
  end

endmodule

`default_nettype wire

// File: hw/register_file.sv
`timescale 1ns/10ps
`default_nettype none

module register_file (
  input  wire                             clk,
  input  wire                             arst_n,
  input  wire  [rv32_pkg::REG_ADDR_W-1:0] rs1_addr,
  input  wire  [rv32_pkg::REG_ADDR_W-1:0] rs2_addr,
  output logic [rv32_pkg::XLEN-1:0]       rs1_data,
  output logic [rv32_pkg::XLEN-1:0]       rs2_data,
  input  wire                             wr_en,
  input  wire  [rv32_pkg::REG_ADDR_W-1:0] wr_addr,
  input  wire  [rv32_pkg::XLEN-1:0]       wr_data
);

  // x0 has no storage
  logic [rv32_pkg::XLEN-1:0] regs [1:rv32_pkg::NUM_REGS-1];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < rv32_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

// File: hw/execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
  input  wire                             clk,
  input  wire                             arst_n,
  input  wire                             dec_valid,
  input  wire  rv32_pkg::alu_op_e         dec_alu_op,
  input  wire  [rv32_pkg::REG_ADDR_W-1:0] dec_rs1,
  input  wire  [rv32_pkg::REG_ADDR_W-1:0] dec_rs2,
  input  wire  [rv32_pkg::REG_ADDR_W-1:0] dec_rd,
  input  wire  [rv32_pkg::XLEN-1:0]       dec_imm,
  input  wire                             dec_use_imm,
  input  wire                             dec_write,
  output logic [rv32_pkg::REG_ADDR_W-1:0] rs1_addr,
  output logic [rv32_pkg::REG_ADDR_W-1:0] rs2_addr,
  input  wire  [rv32_pkg::XLEN-1:0]       rs1_data,
  input  wire  [rv32_pkg::XLEN-1:0]       rs2_data,
  output logic                            wr_en,
  output logic [rv32_pkg::REG_ADDR_W-1:0] wr_addr,
  output logic [rv32_pkg::XLEN-1:0]       wr_data,
  output logic                            retire_valid,
  output logic [rv32_pkg::REG_ADDR_W-1:0] retire_rd,
  output logic [rv32_pkg::XLEN-1:0]       retire_data
);

  localparam int SHAMT_W = $clog2(rv32_pkg::XLEN);

  logic [rv32_pkg::XLEN-1:0] op_a;
  logic [rv32_pkg::XLEN-1:0] op_b;
  logic [SHAMT_W-1:0]        shamt;
  logic [rv32_pkg::XLEN-1:0] result;

  assign rs1_addr = dec_rs1;
  assign rs2_addr = dec_rs2;

  assign op_a  = rs1_data;
  assign op_b  = dec_use_imm ? dec_imm : rs2_data;
  assign shamt = op_b[SHAMT_W-1:0];

  always_comb begin
    case (dec_alu_op)
      rv32_pkg::ADD:    result = op_a + op_b;
      rv32_pkg::SUB:    result = op_a - op_b;
      rv32_pkg::AND:    result = op_a & op_b;
      rv32_pkg::OR:     result = op_a | op_b;
      rv32_pkg::XOR:    result = op_a ^ op_b;
      rv32_pkg::SLT:    result = {{(rv32_pkg::XLEN - 1){1'b0}}, $signed(op_a) < $signed(op_b)};
      rv32_pkg::SLL:    result = op_a << shamt;
      rv32_pkg::SRL:    result = op_a >> shamt;
      // arithmetic shift keeps the sign
      rv32_pkg::SRA:    result = $signed(op_a) >>> shamt;
      rv32_pkg::PASS_B: result = op_b;
      default:          result = '0;
    endcase
  end

  // regfile write lands on the same edge as retire
  assign wr_en   = dec_valid && dec_write;
  assign wr_addr = dec_rd;
  assign wr_data = result;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= dec_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (dec_valid) begin
      retire_rd   <= dec_rd;
      retire_data <= result;
    end
  end

endmodule

`default_nettype wire

// File: hw/rv32_core.sv
`timescale 1ns/10ps
`default_nettype none

module rv32_core #(
  parameter logic [rv32_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  wire                             clk,
  input  wire                             arst_n,
  output logic                            ibus_cyc,
  output logic                            ibus_stb,
  output logic [rv32_pkg::XLEN-1:0]       ibus_adr,
  input  wire                             ibus_ack,
  input  wire  [rv32_pkg::XLEN-1:0]       ibus_rdata,
  output logic                            retire_valid,
  output logic [rv32_pkg::REG_ADDR_W-1:0] retire_rd,
  output logic [rv32_pkg::XLEN-1:0]       retire_data
);

  // fetch to decode
  logic                            fetch_valid;
  logic [rv32_pkg::XLEN-1:0]       fetch_instr;

  // decode to execute
  logic                            dec_valid;
  rv32_pkg::alu_op_e               dec_alu_op;
  logic [rv32_pkg::REG_ADDR_W-1:0] dec_rs1;
  logic [rv32_pkg::REG_ADDR_W-1:0] dec_rs2;
  logic [rv32_pkg::REG_ADDR_W-1:0] dec_rd;
  logic [rv32_pkg::XLEN-1:0]       dec_imm;
  logic                            dec_use_imm;
  logic                            dec_write;

  // register file ports
  logic [rv32_pkg::REG_ADDR_W-1:0] rs1_addr;
  logic [rv32_pkg::REG_ADDR_W-1:0] rs2_addr;
  logic [rv32_pkg::XLEN-1:0]       rs1_data;
  logic [rv32_pkg::XLEN-1:0]       rs2_data;
  logic                            wr_en;
  logic [rv32_pkg::REG_ADDR_W-1:0] wr_addr;
  logic [rv32_pkg::XLEN-1:0]       wr_data;

  fetch_stage #(
    .RESET_PC(RESET_PC)
  ) fetch_stage_inst (
    .clk        (clk),
    .arst_n     (arst_n),
    .ibus_cyc   (ibus_cyc),
    .ibus_stb   (ibus_stb),
    .ibus_adr   (ibus_adr),
    .ibus_ack   (ibus_ack),
    .ibus_rdata (ibus_rdata),
    .fetch_valid(fetch_valid),
    .fetch_instr(fetch_instr)
  );

  decode_stage decode_stage_inst (
    .clk        (clk),
    .arst_n     (arst_n),
    .fetch_valid(fetch_valid),
    .fetch_instr(fetch_instr),
    .dec_valid  (dec_valid),
    .dec_alu_op (dec_alu_op),
    .dec_rs1    (dec_rs1),
    .dec_rs2    (dec_rs2),
    .dec_rd     (dec_rd),
    .dec_imm    (dec_imm),
    .dec_use_imm(dec_use_imm),
    .dec_write  (dec_write)
  );

  execute_stage execute_stage_inst (
    .clk         (clk),
    .arst_n      (arst_n),
    .dec_valid   (dec_valid),
    .dec_alu_op  (dec_alu_op),
    .dec_rs1     (dec_rs1),
    .dec_rs2     (dec_rs2),
    .dec_rd      (dec_rd),
    .dec_imm     (dec_imm),
    .dec_use_imm (dec_use_imm),
    .dec_write   (dec_write),
    .rs1_addr    (rs1_addr),
    .rs2_addr    (rs2_addr),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .retire_valid(retire_valid),
    .retire_rd   (retire_rd),
    .retire_data (retire_data)
  );

  register_file register_file_inst (
    .clk     (clk),
    .arst_n  (arst_n),
    .rs1_addr(rs1_addr),
    .rs2_addr(rs2_addr),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data)
  );

endmodule

`default_nettype wire

// File: bench/rv32_core_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module rv32_core_asserts (
  input wire                      clk,
  input wire                      arst_n,
  input wire                      ibus_cyc,
  input wire                      ibus_stb,
  input wire [rv32_pkg::XLEN-1:0] ibus_adr,
  input wire                      ibus_ack,
  input wire                      retire_valid
);

  // failed assertions, read back by the testbench
  int error_count = 0;

  stb_implies_cyc: assert property (@(posedge clk) disable iff (!arst_n)
    ibus_stb |-> ibus_cyc)
  else begin
    error_count++;
    $error("ibus_stb high without ibus_cyc");
  end

  // address held until the slave acknowledges
  adr_stable: assert property (@(posedge clk) disable iff (!arst_n)
    (ibus_stb && !ibus_ack) |=> $stable(ibus_adr))
  else begin
    error_count++;
    $error("ibus_adr moved while waiting");
  end

  adr_aligned: assert property (@(posedge clk) disable iff (!arst_n)
    ibus_cyc |-> (ibus_adr[1:0] == 2'b00))
  else begin
    error_count++;
    $error("ibus_adr not word aligned");
  end

  retire_quiet_in_reset: assert property (@(posedge clk)
    !arst_n |-> !retire_valid)
  else begin
    error_count++;
    $error("retire_valid high during reset");
  end

endmodule

bind rv32_core rv32_core_asserts rv32_core_asserts_inst (
  .clk         (clk),
  .arst_n      (arst_n),
  .ibus_cyc    (ibus_cyc),
  .ibus_stb    (ibus_stb),
  .ibus_adr    (ibus_adr),
  .ibus_ack    (ibus_ack),
  .retire_valid(retire_valid)
);

`default_nettype wire

// File: bench/rv32_core_tb.sv
`timescale 1ns/10ps
`default_nettype none

module rv32_core_tb;

  localparam int CLK_PERIOD     = 100;
  localparam int RESET_CYCLES   = 10;
  localparam int PROG_WORDS     = 256;
  localparam int TIMEOUT_CYCLES = PROG_WORDS * 5 + 100;
  localparam int NUM_TESTS      = 5;

  logic                            clk;
  logic                            arst_n;
  logic                            ibus_cyc;
  logic                            ibus_stb;
  logic [rv32_pkg::XLEN-1:0]       ibus_adr;
  logic                            ibus_ack;
  logic [rv32_pkg::XLEN-1:0]       ibus_rdata;
  logic                            retire_valid;
  logic [rv32_pkg::REG_ADDR_W-1:0] retire_rd;
  logic [rv32_pkg::XLEN-1:0]       retire_data;

  logic [31:0] lfsr;
  logic [31:0] prog [PROG_WORDS];
  logic [31:0] model_regs [rv32_pkg::NUM_REGS];
  logic [31:0] next_adr;
  logic [1:0]  idle_left;
  logic [4:0]  exp_rd_q [$];
  logic [31:0] exp_data_q [$];
  int          exp_test_q [$];
  int          test_errors [NUM_TESTS];
  int          checks_done;
  int          words_sent;
  int          kept_count;
  int          retire_count;

  rv32_core #(
    .RESET_PC('0)
  ) rv32_core_inst (
    .clk         (clk),
    .arst_n      (arst_n),
    .ibus_cyc    (ibus_cyc),
    .ibus_stb    (ibus_stb),
    .ibus_adr    (ibus_adr),
    .ibus_ack    (ibus_ack),
    .ibus_rdata  (ibus_rdata),
    .retire_valid(retire_valid),
    .retire_rd   (retire_rd),
    .retire_data (retire_data)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // galois lfsr stepped once per bit taken
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int k = 0; k < n; k++) begin
      bits = {bits[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return bits;
  endfunction

  function automatic logic [31:0] random_word();
    rv32_pkg::instr_u w;
    logic [3:0]       kind;
    logic [2:0]       f3;
    w = '0;
    kind = lfsr_bits(4);
    f3 = lfsr_bits(3);
    // sltu is not part of the core
    if (f3 == 3'b011) begin
      f3 = rv32_pkg::F3_SLT;
    end
    w.r.rd = lfsr_bits(3);
    w.r.rs1 = lfsr_bits(3);
    if (kind == 4'd0) begin
      w = lfsr_bits(32);
      if (w.r.opcode == rv32_pkg::OP || w.r.opcode == rv32_pkg::OP_IMM ||
          w.r.opcode == rv32_pkg::LUI) begin
        w.r.opcode = 7'b0000011;
      end
    end else if (kind <= 4'd2) begin
      w.u.opcode = rv32_pkg::LUI;
      w.u.imm = lfsr_bits(20);
    end else if (kind <= 4'd9) begin
      w.r.opcode = rv32_pkg::OP;
      w.r.funct3 = f3;
      w.r.rs2 = lfsr_bits(3);
      if ((f3 == rv32_pkg::F3_ADD_SUB || f3 == rv32_pkg::F3_SRL_SRA) && lfsr_bits(1)) begin
        w.r.funct7 = rv32_pkg::F7_ALT;
      end
    end else begin
      w.i.opcode = rv32_pkg::OP_IMM;
      w.i.funct3 = f3;
      w.i.imm = lfsr_bits(12);
      if (f3 == rv32_pkg::F3_SLL || f3 == rv32_pkg::F3_SRL_SRA) begin
        w.i.imm[11:5] = (f3 == rv32_pkg::F3_SRL_SRA && lfsr_bits(1)) ? rv32_pkg::F7_ALT
                                                                    : rv32_pkg::F7_BASE;
      end
    end
    return w;
  endfunction

  // reference model stepped once per accepted word
  function automatic void model_step(input logic [31:0] word);
    rv32_pkg::instr_u w;
    logic [31:0]      a;
    logic [31:0]      b;
    logic [31:0]      res;
    logic             is_r;
    w = word;
    is_r = w.r.opcode == rv32_pkg::OP;
    a = model_regs[w.r.rs1];
    b = is_r ? model_regs[w.r.rs2] : {{20{w.i.imm[11]}}, w.i.imm};
    case (w.r.funct3)
      rv32_pkg::F3_ADD_SUB: res = (is_r && w.r.funct7[5]) ? a - b : a + b;
      rv32_pkg::F3_SLL:     res = a << b[4:0];
      rv32_pkg::F3_SLT:     res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      rv32_pkg::F3_XOR:     res = a ^ b;
      rv32_pkg::F3_OR:      res = a | b;
      rv32_pkg::F3_AND:     res = a & b;
      default:              res = a >> b[4:0];
    endcase
    if (w.r.funct3 == rv32_pkg::F3_SRL_SRA && w.r.funct7[5]) begin
      res = $signed(a) >>> b[4:0];
    end
    if (w.r.opcode == rv32_pkg::LUI) begin
      res = {w.u.imm, 12'h000};
    end
    if (is_r || w.r.opcode == rv32_pkg::OP_IMM || w.r.opcode == rv32_pkg::LUI) begin
      kept_count++;
      if (w.r.rd != 5'd0) begin
        model_regs[w.r.rd] = res;
      end
      exp_rd_q.push_back(w.r.rd);
      exp_data_q.push_back(res);
      exp_test_q.push_back(is_r ? 2 : 3);
    end
  endfunction

  task automatic check_value(input int test_id, input string name,
                             input logic [31:0] expected, input logic [31:0] actual);
    checks_done++;
    if (actual !== expected) begin
      $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
      test_errors[test_id]++;
    end
  endtask

  function automatic string test_name(input int id);
    case (id)
      0:       return "reset";
      1:       return "fetch sequence";
      2:       return "register-register results";
      3:       return "immediate and lui results";
      default: return "x0 and discards";
    endcase
  endfunction

  task automatic report_test(input int id);
    $display("test %0d %s: %0d errors", id, test_name(id), test_errors[id]);
  endtask

  // wishbone slave with 1 to 3 idle cycles between acks
  always @(posedge clk) begin
    if (!arst_n) begin
      ibus_ack <= 1'b0;
      idle_left <= 2'd1;
    end else if (ibus_ack) begin
      check_value(1, "ibus_adr", next_adr, ibus_adr);
      next_adr = next_adr + 32'd4;
      model_step(ibus_rdata);
      words_sent++;
      ibus_ack <= 1'b0;
      idle_left <= 2'd1 + 2'(lfsr_bits(2) % 3);
    end else if (idle_left > 2'd1) begin
      idle_left <= idle_left - 2'd1;
    end else if (ibus_cyc && ibus_stb && words_sent < PROG_WORDS) begin
      ibus_ack <= 1'b1;
      ibus_rdata <= prog[ibus_adr[9:2]];
    end
  end

  always @(posedge clk) begin : retire_check
    int id;
    if (arst_n && retire_valid) begin
      retire_count++;
      if (exp_rd_q.size() == 0) begin
        $display("ERROR time=%0t retire with no instruction outstanding", $time);
        test_errors[4]++;
      end else begin
        id = exp_test_q.pop_front();
        check_value(id, "retire_rd", exp_rd_q.pop_front(), retire_rd);
        check_value(id, "retire_data", exp_data_q.pop_front(), retire_data);
      end
    end
  end

  // x0 reads in execute stay zero
  always @(posedge clk) begin
    if (arst_n && rv32_core_inst.dec_valid) begin
      if (rv32_core_inst.rs1_addr == 5'd0) begin
        check_value(4, "rs1_data", 32'd0, rv32_core_inst.rs1_data);
      end
      if (rv32_core_inst.rs2_addr == 5'd0) begin
        check_value(4, "rs2_data", 32'd0, rv32_core_inst.rs2_data);
      end
    end
  end

  initial begin
    #((RESET_CYCLES + TIMEOUT_CYCLES) * CLK_PERIOD);
    $display("timeout: program not finished after %0d cycles", RESET_CYCLES + TIMEOUT_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    int total;
    int assert_errors;
    arst_n <= 1'b0;
    ibus_ack = 1'b0;
    ibus_rdata = '0;
    lfsr = 32'hfee0;
    next_adr = '0;
    checks_done = 0;
    words_sent = 0;
    kept_count = 0;
    retire_count = 0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      test_errors[t] = 0;
    end
    for (int r = 0; r < rv32_pkg::NUM_REGS; r++) begin
      model_regs[r] = '0;
    end
    for (int n = 0; n < PROG_WORDS; n++) begin
      prog[n] = random_word();
    end

    for (int c = 0; c < RESET_CYCLES; c++) begin
      @(posedge clk);
      check_value(0, "ibus_cyc", 32'd0, ibus_cyc);
      check_value(0, "ibus_stb", 32'd0, ibus_stb);
      check_value(0, "retire_valid", 32'd0, retire_valid);
    end
    arst_n <= 1'b1;
    @(posedge clk);
    check_value(0, "ibus_cyc", 32'd0, ibus_cyc);
    check_value(0, "ibus_stb", 32'd0, ibus_stb);
    check_value(0, "retire_valid", 32'd0, retire_valid);
    check_value(0, "ibus_adr", 32'd0, ibus_adr);
    report_test(0);

    wait (words_sent == PROG_WORDS);
    // last word retires two edges after its ack
    repeat (4) @(posedge clk);
    check_value(4, "retire_count", kept_count, retire_count);
    check_value(4, "expected_queue_size", 32'd0, exp_rd_q.size());
    for (int t = 1; t < NUM_TESTS; t++) begin
      report_test(t);
    end

    assert_errors = rv32_core_inst.rv32_core_asserts_inst.error_count;
    total = assert_errors;
    for (int t = 0; t < NUM_TESTS; t++) begin
      total += test_errors[t];
    end
    $display("checks %0d, errors %0d (assertions %0d), retired %0d, kept %0d, discarded %0d",
             checks_done, total, assert_errors, retire_count, kept_count,
             PROG_WORDS - kept_count);
    if (total == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
hw/rv32_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/register_file.sv
hw/execute_stage.sv
hw/rv32_core.sv
bench/rv32_core_asserts.sv
bench/rv32_core_tb.sv
